//--- common/rv_pkg.sv
package rv_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // major opcodes handled by the pipeline
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct7 value selecting SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm12;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]          imm20;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } u_fmt_t;

    // one instruction word, read in whichever format the opcode implies
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic                 valid;
        alu_op_e              op;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [XLEN-1:0]      imm;
        logic                 use_imm;
        logic                 writes_rd;
        logic                 illegal;
    } dec_t;

    // decoded record lined up with the register file read data
    typedef struct packed {
        logic                 valid;
        alu_op_e              op;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [XLEN-1:0]      imm;
        logic                 use_imm;
        logic                 writes_rd;
        logic                 illegal;
        logic [XLEN-1:0]      operand_a;
        logic [XLEN-1:0]      operand_b;
    } rd_t;

    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      value;
        logic                 write;
        logic                 illegal;
    } res_t;

endpackage

//--- rtl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
#(
    parameter int REG_COUNT = 32
)
(
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_instr_valid,
    input  rv_pkg::instr_u i_instr,
    output rv_pkg::dec_t   o_dec
);

    import rv_pkg::*;

    dec_t       dec_c;
    dec_t       dec_q;
    logic [6:0] opcode;
    logic [6:0] shift_f7;
    logic       use_rs1;
    logic       use_rs2;
    logic       bad_enc;
    logic       bad_idx;

    // funct3 meaning is shared by the register and immediate forms
    function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic logic out_of_range(input logic [REG_IDX_W-1:0] idx);
        return int'(idx) >= REG_COUNT;
    endfunction

    assign opcode   = i_instr.r.opcode;
    assign shift_f7 = i_instr.i.imm12[11:5];

    always_comb
    begin
        dec_c       = '0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        bad_enc     = 1'b0;
        dec_c.valid = i_instr_valid;
        dec_c.op    = ALU_ADD;
        dec_c.rd    = i_instr.r.rd;
        case (opcode)
            OPC_OP:
            begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                dec_c.op = f3_op(i_instr.r.funct3, i_instr.r.funct7 == F7_ALT);
                if (i_instr.r.funct7 == F7_ALT)
                    bad_enc = !(i_instr.r.funct3 inside {3'b000, 3'b101});
                else
                    bad_enc = (i_instr.r.funct7 != 7'b0);
            end
            OPC_OP_IMM:
            begin
                use_rs1       = 1'b1;
                dec_c.use_imm = 1'b1;
                dec_c.imm     = {{(XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};
                // only shifts use the upper immediate bits as funct7
                dec_c.op = f3_op(i_instr.i.funct3,
                                 i_instr.i.funct3 == 3'b101 && shift_f7 == F7_ALT);
                if (i_instr.i.funct3 == 3'b001)
                    bad_enc = (shift_f7 != 7'b0);
                else if (i_instr.i.funct3 == 3'b101)
                    bad_enc = (shift_f7 != 7'b0) && (shift_f7 != F7_ALT);
            end
            OPC_LUI:
            begin
                dec_c.op      = ALU_PASS_B;
                dec_c.use_imm = 1'b1;
                dec_c.imm     = {i_instr.u.imm20, 12'b0};
            end
            default:
                bad_enc = 1'b1;
        endcase

        bad_idx = out_of_range(i_instr.r.rd)
                | (use_rs1 & out_of_range(i_instr.r.rs1))
                | (use_rs2 & out_of_range(i_instr.r.rs2));

        dec_c.illegal   = bad_enc | bad_idx;
        dec_c.writes_rd = !dec_c.illegal && (dec_c.rd != '0);
        // unused or illegal source fields stay zero so nothing forwards on them
        if (!dec_c.illegal)
        begin
            dec_c.rs1 = use_rs1 ? i_instr.r.rs1 : '0;
            dec_c.rs2 = use_rs2 ? i_instr.r.rs2 : '0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        dec_q <= dec_c;
        if (!i_rst_n)
            dec_q.valid <= 1'b0;
    end

    assign o_dec = dec_q;

endmodule

//--- rv_regs/rv_regs.sv
`timescale 1ns/1ps

module rv_regs
#(
    parameter int REG_COUNT = 32
)
(
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_read_enable,
    input  logic [rv_pkg::REG_IDX_W-1:0] i_rs1,
    input  logic [rv_pkg::REG_IDX_W-1:0] i_rs2,
    input  logic [rv_pkg::REG_IDX_W-1:0] i_rd,
    input  logic                         i_write,
    input  logic [rv_pkg::XLEN-1:0]      i_data,
    output logic [rv_pkg::XLEN-1:0]      o_data1,
    output logic [rv_pkg::XLEN-1:0]      o_data2
);

    import rv_pkg::*;

    logic [XLEN-1:0]      reg_data [REG_COUNT];
    logic [XLEN-1:0]      rdata1;
    logic [XLEN-1:0]      rdata2;
    logic [REG_IDX_W-1:0] rs1_q;
    logic [REG_IDX_W-1:0] rs2_q;
    logic                 wr_en;

    // no writes while reset is held
    assign wr_en = i_rst_n & i_write;

    always_ff @(posedge i_clk)
    begin
        if (wr_en)
            reg_data[i_rd] <= i_data;
    end

    // read sees the array before a write on the same edge
    always_ff @(posedge i_clk)
    begin
        if (i_read_enable)
        begin
            rdata1 <= reg_data[i_rs1];
            rdata2 <= reg_data[i_rs2];
            rs1_q  <= i_rs1;
            rs2_q  <= i_rs2;
        end
    end

    // x0 is never stored, index 0 reads as zero
    assign o_data1 = (|rs1_q) ? rdata1 : '0;
    assign o_data2 = (|rs2_q) ? rdata2 : '0;

    // decode must have rejected any index outside the file
    a_write_in_range : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_write |-> (int'(i_rd) < REG_COUNT)
    );

    // a read enable only comes from a decoded instruction with in-range sources
    a_read_in_range : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_read_enable |-> (int'(i_rs1) < REG_COUNT) && (int'(i_rs2) < REG_COUNT)
    );

endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  rv_pkg::dec_t            i_dec,
    input  logic [rv_pkg::XLEN-1:0] i_data1,
    input  logic [rv_pkg::XLEN-1:0] i_data2,
    output rv_pkg::res_t            o_res
);

    import rv_pkg::*;

    dec_t                 dec_q;
    rd_t                  rd_s;
    res_t                 res_q;
    logic                 ret_valid;
    logic [REG_IDX_W-1:0] ret_rd;
    logic [XLEN-1:0]      ret_value;
    logic [XLEN-1:0]      op_a;
    logic [XLEN-1:0]      fwd_b;
    logic [XLEN-1:0]      op_b;
    logic [XLEN-1:0]      alu_out;

    // nearer producer first, then the write that retired last
    function automatic logic [XLEN-1:0] fwd(
        input logic [REG_IDX_W-1:0] idx,
        input logic [XLEN-1:0]      raw
    );
        if (res_q.write && res_q.rd == idx)
            return res_q.value;
        else if (ret_valid && ret_rd == idx)
            return ret_value;
        else
            return raw;
    endfunction

    // one cycle of delay lines the record up with the file read data
    always_ff @(posedge i_clk)
    begin
        dec_q <= i_dec;
        if (!i_rst_n)
            dec_q.valid <= 1'b0;
    end

    always_comb
    begin
        rd_s.valid     = dec_q.valid;
        rd_s.op        = dec_q.op;
        rd_s.rd        = dec_q.rd;
        rd_s.rs1       = dec_q.rs1;
        rd_s.rs2       = dec_q.rs2;
        rd_s.imm       = dec_q.imm;
        rd_s.use_imm   = dec_q.use_imm;
        rd_s.writes_rd = dec_q.writes_rd;
        rd_s.illegal   = dec_q.illegal;
        rd_s.operand_a = i_data1;
        rd_s.operand_b = i_data2;
    end

    // write flag is never set for x0, so rs of 0 keeps the zero read
    assign op_a  = fwd(rd_s.rs1, rd_s.operand_a);
    assign fwd_b = fwd(rd_s.rs2, rd_s.operand_b);
    assign op_b  = rd_s.use_imm ? rd_s.imm : fwd_b;

    always_comb
    begin
        case (rd_s.op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_SLT:    alu_out = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_out = XLEN'(op_a < op_b);
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        res_q.valid   <= rd_s.valid;
        res_q.rd      <= rd_s.rd;
        res_q.value   <= alu_out;
        res_q.illegal <= rd_s.illegal;
        res_q.write   <= rd_s.valid && rd_s.writes_rd;
        if (!i_rst_n)
        begin
            res_q.valid <= 1'b0;
            res_q.write <= 1'b0;
        end
    end

    // copy of the write the register file takes on this edge
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            ret_valid <= 1'b0;
        else
            ret_valid <= res_q.write;
        if (res_q.write)
        begin
            ret_rd    <= res_q.rd;
            ret_value <= res_q.value;
        end
    end

    assign o_res = res_q;

    // decode never marks an illegal instruction as writing its destination
    a_illegal_no_write : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (res_q.valid && res_q.illegal) |-> !res_q.write
    );

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core
#(
    parameter int REG_COUNT = 32
)
(
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_instr_valid,
    input  logic [31:0]                  i_instr,
    output logic                         o_result_valid,
    output logic [rv_pkg::REG_IDX_W-1:0] o_result_rd,
    output logic [rv_pkg::XLEN-1:0]      o_result_value,
    output logic                         o_result_illegal
);

    import rv_pkg::*;

    dec_t            dec;
    res_t            res;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;

    rv_decode
    #(
        .REG_COUNT      (REG_COUNT)
    )
    u_decode
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_dec          (dec)
    );

    // reads launch with the decoded strobe, writes come back from retire
    rv_regs
    #(
        .REG_COUNT      (REG_COUNT)
    )
    u_regs
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_read_enable  (dec.valid),
        .i_rs1          (dec.rs1),
        .i_rs2          (dec.rs2),
        .i_rd           (res.rd),
        .i_write        (res.write),
        .i_data         (res.value),
        .o_data1        (rdata1),
        .o_data2        (rdata2)
    );

    rv_execute u_execute
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_dec          (dec),
        .i_data1        (rdata1),
        .i_data2        (rdata2),
        .o_res          (res)
    );

    assign o_result_valid   = res.valid;
    assign o_result_rd      = res.rd;
    assign o_result_value   = res.value;
    assign o_result_illegal = res.illegal;

endmodule

//--- sim/rv_checker.sv
`timescale 1ns/1ps

module rv_checker
(
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  int            i_cycle,
    input  logic          i_push,
    input  logic [127:0]  i_push_name,
    input  logic [4:0]    i_push_rd,
    input  logic [31:0]   i_push_value,
    input  logic          i_push_illegal,
    input  int            i_push_cycle,
    input  logic          i_done,
    input  logic          i_result_valid,
    input  logic [4:0]    i_result_rd,
    input  logic [31:0]   i_result_value,
    input  logic          i_result_illegal,
    output int            o_value_errors,
    output int            o_timing_errors,
    output int            o_other_errors,
    output int            o_pending
);

    logic [127:0] name_q [$];
    logic [4:0]   rd_q [$];
    logic [31:0]  value_q [$];
    logic         illegal_q [$];
    int           cycle_q [$];
    logic [127:0] name;
    int           latency;

    initial
    begin
        o_value_errors  = 0;
        o_timing_errors = 0;
        o_other_errors  = 0;
    end

    assign o_pending = name_q.size();

    always @(posedge i_clk)
    begin
        // valid is cleared on the first reset edge
        if (!i_rst_n && i_cycle >= 1 && i_result_valid !== 1'b0)
        begin
            $display("result strobe seen while reset is held (cycle %0d)", i_cycle);
            o_other_errors++;
        end
        // compare before pushing, a new entry cannot retire on this edge
        if (i_rst_n && i_result_valid === 1'b1)
        begin
            if (name_q.size() == 0)
            begin
                $display("result for rd %0d arrived with nothing outstanding", i_result_rd);
                o_other_errors++;
            end
            else
            begin
                name    = name_q[0];
                latency = i_cycle - cycle_q[0];
                if (latency != 3)
                begin
                    $display("%0s retired after %0d cycles instead of 3", name, latency);
                    o_timing_errors++;
                end
                if (i_result_rd !== rd_q[0])
                begin
                    $display("Error %0s rd: expected %0d, actual %0d", name, rd_q[0],
                             i_result_rd);
                    o_value_errors++;
                end
                if (i_result_illegal !== illegal_q[0])
                begin
                    $display("Error %0s illegal: expected %0b, actual %0b", name,
                             illegal_q[0], i_result_illegal);
                    o_value_errors++;
                end
                else if (!illegal_q[0] && i_result_value !== value_q[0])
                begin
                    $display("Error %0s value: expected %08h, actual %08h", name,
                             value_q[0], i_result_value);
                    o_value_errors++;
                end
                void'(name_q.pop_front());
                void'(rd_q.pop_front());
                void'(value_q.pop_front());
                void'(illegal_q.pop_front());
                void'(cycle_q.pop_front());
            end
        end
        if (i_push === 1'b1)
        begin
            name_q.push_back(i_push_name);
            rd_q.push_back(i_push_rd);
            value_q.push_back(i_push_value);
            illegal_q.push_back(i_push_illegal);
            cycle_q.push_back(i_push_cycle);
        end
        if (i_done === 1'b1 && name_q.size() != 0)
        begin
            $display("%0d results never arrived, first is %0s", name_q.size(), name_q[0]);
            o_other_errors++;
        end
    end

endmodule

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int MAX_ROWS = 64;

    logic         i_clk;
    logic         i_rst_n;
    logic         i_instr_valid;
    logic [31:0]  i_instr;
    logic         o_result_valid;
    logic [4:0]   o_result_rd;
    logic [31:0]  o_result_value;
    logic         o_result_illegal;

    logic         push;
    logic [127:0] push_name;
    logic [4:0]   push_rd;
    logic [31:0]  push_value;
    logic         push_illegal;
    int           push_cycle;
    logic         done;
    int           cycle;
    int           limit;
    int           value_errors;
    int           timing_errors;
    int           other_errors;
    int           pending;

    // stimulus table
    logic [127:0] row_name [MAX_ROWS];
    logic [31:0]  row_instr [MAX_ROWS];
    int           row_gap [MAX_ROWS];
    bit           row_rnd [MAX_ROWS];
    logic [4:0]   row_rd [MAX_ROWS];
    logic [31:0]  row_value [MAX_ROWS];
    logic         row_illegal [MAX_ROWS];
    int           row_count;

    rv_core #(.REG_COUNT(32)) u_rv_core
    (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_instr_valid    (i_instr_valid),
        .i_instr          (i_instr),
        .o_result_valid   (o_result_valid),
        .o_result_rd      (o_result_rd),
        .o_result_value   (o_result_value),
        .o_result_illegal (o_result_illegal)
    );

    rv_checker u_checker
    (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_cycle          (cycle),
        .i_push           (push),
        .i_push_name      (push_name),
        .i_push_rd        (push_rd),
        .i_push_value     (push_value),
        .i_push_illegal   (push_illegal),
        .i_push_cycle     (push_cycle),
        .i_done           (done),
        .i_result_valid   (o_result_valid),
        .i_result_rd      (o_result_rd),
        .i_result_value   (o_result_value),
        .i_result_illegal (o_result_illegal),
        .o_value_errors   (value_errors),
        .o_timing_errors  (timing_errors),
        .o_other_errors   (other_errors),
        .o_pending        (pending)
    );

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic add_row(input logic [127:0] name, input logic [31:0] instr,
                           input int gap, input bit rnd, input logic [4:0] rd,
                           input logic [31:0] value, input logic illegal);
        row_name[row_count]    = name;
        row_instr[row_count]   = instr;
        row_gap[row_count]     = gap;
        row_rnd[row_count]     = rnd;
        row_rd[row_count]      = rd;
        row_value[row_count]   = value;
        row_illegal[row_count] = illegal;
        row_count++;
    endtask

    task automatic build_table();
        // x1..x7 from x0, widely spaced
        add_row("addi_x1", enc_i(12'd5, 3'b000, 1, 0), 3, 0, 1, 32'h00000005, 0);
        add_row("addi_x2", enc_i(12'hffd, 3'b000, 2, 0), 3, 0, 2, 32'hfffffffd, 0);
        add_row("lui_x3", enc_lui(20'h80000, 3), 3, 0, 3, 32'h80000000, 0);
        add_row("addi_x4", enc_i(12'h7ff, 3'b000, 4, 0), 3, 0, 4, 32'h000007ff, 0);
        add_row("addi_x5", enc_i(12'h800, 3'b000, 5, 0), 3, 0, 5, 32'hfffff800, 0);
        add_row("lui_x6", enc_lui(20'h12345, 6), 3, 0, 6, 32'h12345000, 0);
        add_row("addi_x7", enc_i(12'd1, 3'b000, 7, 0), 3, 0, 7, 32'h00000001, 0);
        // register and immediate ALU operations
        add_row("sub_uflow", enc_r(7'h20, 3'b000, 8, 1, 4), 3, 0, 8, 32'hfffff806, 0);
        add_row("add", enc_r(7'h00, 3'b000, 9, 1, 6), 1, 1, 9, 32'h12345005, 0);
        add_row("and", enc_r(7'h00, 3'b111, 10, 6, 5), 1, 1, 10, 32'h12345000, 0);
        add_row("or", enc_r(7'h00, 3'b110, 11, 1, 4), 1, 0, 11, 32'h000007ff, 0);
        add_row("xor", enc_r(7'h00, 3'b100, 12, 2, 1), 1, 1, 12, 32'hfffffff8, 0);
        add_row("slt_neg", enc_r(7'h00, 3'b010, 13, 2, 1), 1, 0, 13, 32'h00000001, 0);
        add_row("sltu_neg", enc_r(7'h00, 3'b011, 14, 2, 1), 1, 1, 14, 32'h00000000, 0);
        add_row("sra_neg", enc_r(7'h20, 3'b101, 15, 3, 1), 1, 0, 15, 32'hfc000000, 0);
        add_row("srl_neg", enc_r(7'h00, 3'b101, 16, 3, 1), 1, 1, 16, 32'h04000000, 0);
        add_row("sll", enc_r(7'h00, 3'b001, 17, 6, 7), 1, 0, 17, 32'h2468a000, 0);
        add_row("slti", enc_i(12'hffe, 3'b010, 18, 2), 1, 1, 18, 32'h00000001, 0);
        add_row("sltiu", enc_i(12'hfff, 3'b011, 19, 1), 1, 0, 19, 32'h00000001, 0);
        add_row("srai", enc_i(12'h404, 3'b101, 20, 3), 1, 1, 20, 32'hf8000000, 0);
        add_row("srli", enc_i(12'h004, 3'b101, 21, 3), 1, 0, 21, 32'h08000000, 0);
        add_row("slli", enc_i(12'h003, 3'b001, 22, 1), 1, 1, 22, 32'h00000028, 0);
        add_row("andi", enc_i(12'h0f0, 3'b111, 23, 4), 1, 0, 23, 32'h000000f0, 0);
        add_row("ori", enc_i(12'h100, 3'b110, 24, 1), 1, 1, 24, 32'h00000105, 0);
        add_row("xori", enc_i(12'hfff, 3'b100, 25, 1), 1, 0, 25, 32'hfffffffa, 0);
        // dependent chains at distance one, two and three
        add_row("chain_a", enc_i(12'd10, 3'b000, 26, 0), 3, 0, 26, 32'd10, 0);
        add_row("chain_d1", enc_i(12'd1, 3'b000, 27, 26), 0, 0, 27, 32'd11, 0);
        add_row("chain_d2", enc_r(7'h00, 3'b000, 28, 26, 27), 0, 0, 28, 32'd21, 0);
        add_row("chain_d3", enc_r(7'h00, 3'b000, 29, 26, 28), 0, 0, 29, 32'd31, 0);
        add_row("chain_same", enc_i(12'd5, 3'b000, 26, 26), 0, 0, 26, 32'd15, 0);
        add_row("chain_over", enc_i(12'd5, 3'b000, 26, 26), 0, 0, 26, 32'd20, 0);
        add_row("prio_d1", enc_i(12'd0, 3'b000, 31, 26), 0, 0, 31, 32'd20, 0);
        add_row("prio_d2", enc_r(7'h00, 3'b000, 30, 26, 0), 0, 0, 30, 32'd20, 0);
        add_row("spaced", enc_r(7'h00, 3'b000, 29, 26, 27), 3, 0, 29, 32'd31, 0);
        // x0 as destination
        add_row("x0_write", enc_i(12'd99, 3'b000, 0, 0), 3, 0, 0, 32'd99, 0);
        add_row("x0_read", enc_r(7'h00, 3'b000, 9, 0, 0), 0, 0, 9, 32'd0, 0);
        add_row("x0_read2", enc_i(12'd7, 3'b000, 10, 0), 0, 0, 10, 32'd7, 0);
        // illegal encodings leave the destination alone
        add_row("bad_opc", 32'h000000ff, 3, 0, 1, 32'd0, 1);
        add_row("slli_f7", enc_i(12'h403, 3'b001, 1, 1), 0, 0, 1, 32'd0, 1);
        add_row("old_x1", enc_i(12'd0, 3'b000, 11, 1), 0, 0, 11, 32'h00000005, 0);
        add_row("bad_f7_r", enc_r(7'h01, 3'b000, 2, 1, 1), 0, 1, 2, 32'd0, 1);
        add_row("old_x2", enc_i(12'd0, 3'b000, 12, 2), 0, 0, 12, 32'hfffffffd, 0);
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
        cycle <= cycle + 1;

    always @(posedge i_clk)
    begin
        if (cycle >= limit)
        begin
            $display("run stopped after %0d cycles without finishing", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        int gap;
        void'($urandom(48542));
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        push          = 1'b0;
        push_name     = '0;
        push_rd       = '0;
        push_value    = '0;
        push_illegal  = 1'b0;
        push_cycle    = 0;
        done          = 1'b0;
        cycle         = 0;
        row_count     = 0;
        build_table();
        limit = 4 + row_count + 3 * row_count + 3 + 20;

        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        for (int r = 0; r < row_count; r++)
        begin
            gap = row_rnd[r] ? int'($urandom % 4) : row_gap[r];
            repeat (gap)
            begin
                @(posedge i_clk);
                i_instr_valid <= 1'b0;
                push          <= 1'b0;
            end
            @(posedge i_clk);
            i_instr_valid <= 1'b1;
            i_instr       <= row_instr[r];
            push          <= 1'b1;
            push_name     <= row_name[r];
            push_rd       <= row_rd[r];
            push_value    <= row_value[r];
            push_illegal  <= row_illegal[r];
            // the DUT samples the strobe on the next edge
            push_cycle    <= cycle + 1;
        end
        @(posedge i_clk);
        i_instr_valid <= 1'b0;
        push          <= 1'b0;
        for (int w = 0; w < 8 && pending != 0; w++)
            @(posedge i_clk);
        repeat (2) @(posedge i_clk);
        done <= 1'b1;
        @(posedge i_clk);
        done <= 1'b0;
        @(posedge i_clk);
        $display("value errors %0d, timing errors %0d, other errors %0d",
                 value_errors, timing_errors, other_errors);
        if (value_errors == 0 && timing_errors == 0 && other_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- vlog.f
common/rv_pkg.sv
rtl/rv_decode.sv
rv_regs/rv_regs.sv
rtl/rv_execute.sv
rtl/rv_core.sv
sim/rv_checker.sv
sim/tb_rv_core.sv
